// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // supported subset, anything else decodes to ILLEGAL
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    LUI,
    JAL,
    BEQ,
    BNE,
    ILLEGAL
  } op_e;

  // --------------------------------------------------
  // stage payloads
  // --------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } fetch_entry_t;

  typedef struct packed {
    logic                  valid;
    op_e                   op;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       offset;
    logic                  illegal;
  } issue_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       result;
    logic                  exception;
  } commit_entry_t;

  // external trace port, same layout as the commit entry
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       result;
    logic                  exception;
  } commit_trace_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // instruction memory
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic [31:0]               instr_rdata_i,
  input  logic                      instr_valid_i,
  // redirects
  input  core_pkg::redirect_t       branch_redirect_i,
  input  core_pkg::redirect_t       exc_redirect_i,
  // to decode
  output core_pkg::fetch_entry_t    fetch_entry_o
);

  logic [core_pkg::XLEN-1:0] pc_d, pc_q;
  core_pkg::fetch_entry_t    entry_d, entry_q;
  logic                      redirect;

  assign redirect     = exc_redirect_i.valid | branch_redirect_i.valid;
  assign instr_addr_o = pc_q;

  // --------------------------------------------------
  // next pc
  // --------------------------------------------------
  always_comb begin
    if (exc_redirect_i.valid) begin
      pc_d = exc_redirect_i.pc;
    end else if (branch_redirect_i.valid) begin
      pc_d = branch_redirect_i.pc;
    end else if (instr_valid_i) begin
      pc_d = pc_q + core_pkg::XLEN'(4);
    end else begin
      // memory not ready yet, hold
      pc_d = pc_q;
    end
  end

  // bubble on a stall or when the fetched word is on the wrong path
  always_comb begin
    entry_d.valid = instr_valid_i & ~redirect;
    entry_d.pc    = pc_q;
    entry_d.instr = instr_rdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q    <= BootAddr;
      entry_q <= '0;
    end else begin
      pc_q    <= pc_d;
      entry_q <= entry_d;
    end
  end

  assign fetch_entry_o = entry_q;

endmodule

`default_nettype wire

// ==== decode_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_issue_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_pkg::fetch_entry_t  fetch_entry_i,
  input  logic                    kill_i,
  // forwarding sources
  input  core_pkg::commit_entry_t ex_fwd_i,
  input  core_pkg::commit_entry_t wb_i,
  output core_pkg::issue_entry_t  issue_entry_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [31:0]                     instr;
  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [core_pkg::REG_ADDR_W-1:0] rs1, rs2;
  logic [core_pkg::XLEN-1:0]       i_imm, u_imm, b_imm, j_imm;
  logic [core_pkg::XLEN-1:0]       rf_rs1, rf_rs2;
  logic [core_pkg::XLEN-1:0]       rs1_val, rs2_val;
  core_pkg::op_e                   op;
  logic                            use_imm;
  core_pkg::issue_entry_t          issue_d, issue_q;

  // x1..x31, x0 is not stored
  logic [core_pkg::XLEN-1:0] regs_q [1:core_pkg::NR_REGS-1];

  assign instr  = fetch_entry_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // --------------------------------------------------
  // immediates
  // --------------------------------------------------
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign u_imm = {instr[31:12], 12'b0};
  assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------------------
  // decoder
  // --------------------------------------------------
  always_comb begin
    op      = core_pkg::ILLEGAL;
    use_imm = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = core_pkg::ADD;
            3'b001:  op = core_pkg::SLL;
            3'b010:  op = core_pkg::SLT;
            3'b100:  op = core_pkg::XOR;
            3'b101:  op = core_pkg::SRL;
            3'b110:  op = core_pkg::OR;
            3'b111:  op = core_pkg::AND;
            default: op = core_pkg::ILLEGAL;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = core_pkg::SUB;
        end
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000:  op = core_pkg::ADD;
          3'b010:  op = core_pkg::SLT;
          3'b100:  op = core_pkg::XOR;
          3'b110:  op = core_pkg::OR;
          3'b111:  op = core_pkg::AND;
          // shifts by immediate, srai is not supported
          3'b001:  op = (funct7 == 7'b0) ? core_pkg::SLL : core_pkg::ILLEGAL;
          3'b101:  op = (funct7 == 7'b0) ? core_pkg::SRL : core_pkg::ILLEGAL;
          default: op = core_pkg::ILLEGAL;
        endcase
      end
      OPC_LUI: op = core_pkg::LUI;
      OPC_JAL: op = core_pkg::JAL;
      OPC_BRANCH: begin
        if (funct3 == 3'b000) begin
          op = core_pkg::BEQ;
        end else if (funct3 == 3'b001) begin
          op = core_pkg::BNE;
        end
      end
      default: op = core_pkg::ILLEGAL;
    endcase
  end

  // --------------------------------------------------
  // register file and forwarding
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wb_i.valid && wb_i.we) begin
      regs_q[wb_i.rd] <= wb_i.result;
    end
  end

  assign rf_rs1 = (rs1 == '0) ? '0 : regs_q[rs1];
  assign rf_rs2 = (rs2 == '0) ? '0 : regs_q[rs2];

  // youngest producer wins
  function automatic logic [core_pkg::XLEN-1:0] fwd_operand(
    input logic [core_pkg::REG_ADDR_W-1:0] addr,
    input logic [core_pkg::XLEN-1:0]       rf_val,
    input core_pkg::commit_entry_t         ex_fwd,
    input core_pkg::commit_entry_t         wb
  );
    logic [core_pkg::XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (ex_fwd.valid && ex_fwd.we && ex_fwd.rd == addr) begin
      val = ex_fwd.result;
    end else if (wb.valid && wb.we && wb.rd == addr) begin
      val = wb.result;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign rs1_val = fwd_operand(rs1, rf_rs1, ex_fwd_i, wb_i);
  assign rs2_val = fwd_operand(rs2, rf_rs2, ex_fwd_i, wb_i);

  // --------------------------------------------------
  // issue register
  // --------------------------------------------------
  always_comb begin
    issue_d.valid     = fetch_entry_i.valid;
    issue_d.op        = op;
    issue_d.pc        = fetch_entry_i.pc;
    issue_d.instr     = instr;
    issue_d.rd        = instr[11:7];
    issue_d.we        = !(op inside {core_pkg::BEQ, core_pkg::BNE, core_pkg::ILLEGAL});
    issue_d.operand_a = (op == core_pkg::LUI) ? '0 : rs1_val;
    issue_d.operand_b = (op == core_pkg::LUI) ? u_imm : (use_imm ? i_imm : rs2_val);
    issue_d.offset    = (op == core_pkg::JAL) ? j_imm : b_imm;
    issue_d.illegal   = (op == core_pkg::ILLEGAL);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= '0;
    end else if (kill_i) begin
      issue_q <= '0;
    end else begin
      issue_q <= issue_d;
    end
  end

  assign issue_entry_o = issue_q;

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_pkg::issue_entry_t  issue_entry_i,
  input  logic                    flush_i,
  output core_pkg::redirect_t     branch_redirect_o,
  output core_pkg::commit_entry_t ex_fwd_o,
  output core_pkg::commit_entry_t commit_entry_o
);

  logic [core_pkg::XLEN-1:0] a, b;
  logic [core_pkg::XLEN-1:0] result;
  logic                      taken;
  core_pkg::commit_entry_t   ex_d, ex_q;

  assign a = issue_entry_i.operand_a;
  assign b = issue_entry_i.operand_b;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (issue_entry_i.op)
      core_pkg::ADD: result = a + b;
      core_pkg::SUB: result = a - b;
      core_pkg::AND: result = a & b;
      core_pkg::OR:  result = a | b;
      core_pkg::XOR: result = a ^ b;
      core_pkg::SLT: result = {{(core_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      core_pkg::SLL: result = a << b[4:0];
      core_pkg::SRL: result = a >> b[4:0];
      core_pkg::LUI: result = b;
      // link address
      core_pkg::JAL: result = issue_entry_i.pc + core_pkg::XLEN'(4);
      default:       result = '0;
    endcase
  end

  // --------------------------------------------------
  // branch resolution, predicted not taken
  // --------------------------------------------------
  always_comb begin
    case (issue_entry_i.op)
      core_pkg::JAL: taken = 1'b1;
      core_pkg::BEQ: taken = (a == b);
      core_pkg::BNE: taken = (a != b);
      default:       taken = 1'b0;
    endcase
  end

  // a trap at commit wins over the branch
  assign branch_redirect_o.valid = issue_entry_i.valid & taken & ~flush_i;
  assign branch_redirect_o.pc    = issue_entry_i.pc + issue_entry_i.offset;

  always_comb begin
    ex_d.valid     = issue_entry_i.valid;
    ex_d.pc        = issue_entry_i.pc;
    ex_d.instr     = issue_entry_i.instr;
    ex_d.rd        = issue_entry_i.rd;
    ex_d.we        = issue_entry_i.we & ~issue_entry_i.illegal;
    ex_d.result    = result;
    ex_d.exception = issue_entry_i.illegal;
  end

  // same-cycle result for dependent instructions in decode
  assign ex_fwd_o = ex_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_q <= '0;
    end else if (flush_i) begin
      ex_q <= '0;
    end else begin
      ex_q <= ex_d;
    end
  end

  assign commit_entry_o = ex_q;

endmodule

`default_nettype wire

// ==== commit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_stage #(
  parameter logic [core_pkg::XLEN-1:0] TrapVector = 32'h100
) (
  input  core_pkg::commit_entry_t commit_entry_i,
  // register write port
  output core_pkg::commit_entry_t wb_o,
  // controller
  output core_pkg::redirect_t     exc_redirect_o,
  output logic                    flush_o,
  output core_pkg::commit_trace_t trace_o
);

  logic exc_commit;

  assign exc_commit = commit_entry_i.valid & commit_entry_i.exception;

  // --------------------------------------------------
  // write-back
  // --------------------------------------------------
  always_comb begin
    wb_o    = commit_entry_i;
    // no write for x0 or a faulting instruction
    wb_o.we = commit_entry_i.valid & commit_entry_i.we & ~commit_entry_i.exception
              & (commit_entry_i.rd != '0);
  end

  // --------------------------------------------------
  // exception and redirect
  // --------------------------------------------------
  assign flush_o              = exc_commit;
  assign exc_redirect_o.valid = exc_commit;
  assign exc_redirect_o.pc    = TrapVector;

  // --------------------------------------------------
  // trace
  // --------------------------------------------------
  always_comb begin
    trace_o.valid     = commit_entry_i.valid;
    trace_o.pc        = commit_entry_i.pc;
    trace_o.instr     = commit_entry_i.instr;
    trace_o.rd        = commit_entry_i.rd;
    trace_o.we        = wb_o.we;
    // a suppressed write shows as zero
    trace_o.result    = wb_o.we ? commit_entry_i.result : '0;
    trace_o.exception = exc_commit;
  end

endmodule

`default_nettype wire

// ==== mini_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_core #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr   = '0,
  parameter logic [core_pkg::XLEN-1:0] TrapVector = 32'h100
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic [31:0]               instr_rdata_i,
  input  logic                      instr_valid_i,
  output core_pkg::commit_trace_t   trace_o
);

  // --------------------------------------------------
  // stage interconnect
  // --------------------------------------------------
  core_pkg::fetch_entry_t  fetch_entry_if_id;
  core_pkg::issue_entry_t  issue_entry_id_ex;
  core_pkg::commit_entry_t commit_entry_ex_commit;
  core_pkg::commit_entry_t ex_fwd;
  core_pkg::commit_entry_t wb;
  core_pkg::redirect_t     branch_redirect;
  core_pkg::redirect_t     exc_redirect;
  logic                    flush;
  logic                    kill_id;

  // wrong-path work behind a taken branch or a trap
  assign kill_id = branch_redirect.valid | flush;

  fetch_stage #(
    .BootAddr ( BootAddr )
  ) fetch_stage_i (
    .clk_i,
    .rst_ni,
    .instr_addr_o,
    .instr_rdata_i,
    .instr_valid_i,
    .branch_redirect_i ( branch_redirect   ),
    .exc_redirect_i    ( exc_redirect      ),
    .fetch_entry_o     ( fetch_entry_if_id )
  );

  decode_issue_stage decode_issue_stage_i (
    .clk_i,
    .rst_ni,
    .fetch_entry_i ( fetch_entry_if_id ),
    .kill_i        ( kill_id           ),
    .ex_fwd_i      ( ex_fwd            ),
    .wb_i          ( wb                ),
    .issue_entry_o ( issue_entry_id_ex )
  );

  ex_stage ex_stage_i (
    .clk_i,
    .rst_ni,
    .issue_entry_i     ( issue_entry_id_ex      ),
    .flush_i           ( flush                  ),
    .branch_redirect_o ( branch_redirect        ),
    .ex_fwd_o          ( ex_fwd                 ),
    .commit_entry_o    ( commit_entry_ex_commit )
  );

  commit_stage #(
    .TrapVector ( TrapVector )
  ) commit_stage_i (
    .commit_entry_i ( commit_entry_ex_commit ),
    .wb_o           ( wb                     ),
    .exc_redirect_o ( exc_redirect           ),
    .flush_o        ( flush                  ),
    .trace_o
  );

endmodule

`default_nettype wire

// ==== tb_mini_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRIVE_DELAY  = 1;
  localparam int unsigned RST_CYCLES   = 16;
  localparam int unsigned MEM_WORDS    = 1024;
  // word index of the record count and of the first expected record
  localparam int unsigned COUNT_IDX    = 'h7f;
  localparam int unsigned REC_BASE     = 'h80;
  localparam int unsigned REC_WORDS    = 6;
  localparam int unsigned MAX_RECORDS  = (MEM_WORDS - REC_BASE) / REC_WORDS;
  localparam int unsigned TIMEOUT_MULT = 20;
  localparam logic [31:0] LFSR_SEED    = 32'hc8d2_e4c2;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic                    clk_i;
  logic                    rst_ni;
  logic [31:0]             instr_addr_o;
  logic [31:0]             instr_rdata_i;
  logic                    instr_valid_i;
  core_pkg::commit_trace_t trace_o;

  // program image and expected commit records share one array
  logic [31:0] stim_mem [MEM_WORDS];
  logic [31:0] lfsr_q;
  logic        stim_loaded;
  int unsigned n_expected;
  int unsigned n_errors;
  int unsigned tests_run;
  int unsigned tests_failed;

  mini_core #(
    .BootAddr   ( 32'h0   ),
    .TrapVector ( 32'h100 )
  ) mini_core_i (
    .clk_i,
    .rst_ni,
    .instr_addr_o,
    .instr_rdata_i,
    .instr_valid_i,
    .trace_o
  );

  // --------------------------------------------------
  // instruction memory and stalls
  // --------------------------------------------------
  assign instr_rdata_i = (instr_addr_o[31:12] == '0) ? stim_mem[instr_addr_o[11:2]]
                                                     : ~instr_addr_o;

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  // one lfsr bit per cycle decides whether memory answers
  always @(posedge clk_i) begin
    #(DRIVE_DELAY);
    lfsr_q        = lfsr_next(lfsr_q);
    instr_valid_i = lfsr_q[0];
  end

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      n_errors++;
      $display("error at %0d ns: %s is %08h, expected %08h", $time, what, got, expected);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (n_errors != errors_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic watch_reset_and_first_commit();
    int unsigned errors_before;
    int unsigned edges;
    int unsigned i;
    errors_before = n_errors;
    edges         = 0;
    for (i = 0; i < RST_CYCLES; i++) begin
      @(negedge clk_i);
      check_value("trace valid during reset", 32'(trace_o.valid), 32'd0);
    end
    @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    // edges counted from the first accepted fetch
    while (edges < 3) begin
      @(posedge clk_i);
      if (edges != 0 || instr_valid_i) begin
        edges++;
      end
      @(negedge clk_i);
      if (edges < 3) begin
        check_value("trace valid before first commit", 32'(trace_o.valid), 32'd0);
      end
    end
    check_value("first commit latency", 32'(trace_o.valid), 32'd1);
    finish_test("reset_and_first_commit", errors_before);
  endtask

  task automatic compare_commit_trace();
    int unsigned k;
    int unsigned base;
    int unsigned errors_before;
    string       name;
    for (k = 0; k < n_expected; k++) begin
      errors_before = n_errors;
      base          = REC_BASE + k * REC_WORDS;
      while (trace_o.valid !== 1'b1) begin
        @(negedge clk_i);
      end
      check_value("trace pc", trace_o.pc, stim_mem[base]);
      check_value("trace instr", trace_o.instr, stim_mem[base+1]);
      check_value("trace rd", 32'(trace_o.rd), stim_mem[base+2]);
      check_value("trace we", 32'(trace_o.we), stim_mem[base+3]);
      check_value("trace result", trace_o.result, stim_mem[base+4]);
      check_value("trace exception", 32'(trace_o.exception), stim_mem[base+5]);
      name = $sformatf("commit_%0d_pc_%08h", k, stim_mem[base]);
      finish_test(name, errors_before);
      @(negedge clk_i);
    end
  endtask

  initial begin : main
    int unsigned i;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    lfsr_q        = LFSR_SEED;
    n_errors      = 0;
    tests_run     = 0;
    tests_failed  = 0;
    stim_loaded   = 1'b0;
    // unused words read as the inverted byte address
    for (i = 0; i < MEM_WORDS; i++) begin
      stim_mem[i] = ~(32'(i) << 2);
    end
    $readmemh("mini_core_stim.txt", stim_mem);
    n_expected  = stim_mem[COUNT_IDX];
    stim_loaded = 1'b1;
    if (n_expected == 0 || n_expected > MAX_RECORDS) begin
      n_errors++;
      $display("stimulus file holds no usable count of expected commits");
    end else begin
      watch_reset_and_first_commit();
      compare_commit_trace();
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // limit scales with the number of expected commits
  initial begin : watchdog
    longint unsigned limit;
    wait (stim_loaded === 1'b1);
    limit = longint'(TIMEOUT_MULT) * n_expected * CLK_PERIOD;
    #(limit);
    $display("run timed out after %0d ns, expected commits are still missing", limit);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_core_stim.txt ====
// words from byte 0: program image, trap handler at byte 0x100 (word 40), count at word 7f
// from word 80 one commit per line: pc instr rd we value exception
@00
00500093 ffd00113 002081b3 40208233
0020f2b3 0020e333 0020c3b3 00112433
001094b3 00115533 123455b7 6785c613
00461693 0086d713 f0076793 0ff7f813
10082893 00708013 00100933 01208663
00100993 00200993 00109463 00209663
00300993 00400993 00c00a6f 00500993
00600993 004a0a93 00002083
@40
0000006f
@7f
0000001c
@80
00000000 00500093 01 1 00000005 0
00000004 ffd00113 02 1 fffffffd 0
00000008 002081b3 03 1 00000002 0
0000000c 40208233 04 1 00000008 0
00000010 0020f2b3 05 1 00000005 0
00000014 0020e333 06 1 fffffffd 0
00000018 0020c3b3 07 1 fffffff8 0
0000001c 00112433 08 1 00000001 0
00000020 001094b3 09 1 000000a0 0
00000024 00115533 0a 1 07ffffff 0
00000028 123455b7 0b 1 12345000 0
0000002c 6785c613 0c 1 12345678 0
00000030 00461693 0d 1 23456780 0
00000034 0086d713 0e 1 00234567 0
00000038 f0076793 0f 1 ffffff67 0
0000003c 0ff7f813 10 1 00000067 0
00000040 10082893 11 1 00000001 0
00000044 00708013 00 0 00000000 0
00000048 00100933 12 1 00000005 0
0000004c 01208663 0c 0 00000000 0
00000058 00109463 08 0 00000000 0
0000005c 00209663 0c 0 00000000 0
00000068 00c00a6f 14 1 0000006c 0
00000074 004a0a93 15 1 00000070 0
00000078 00002083 01 0 00000000 1
00000100 0000006f 00 0 00000000 0
00000100 0000006f 00 0 00000000 0
00000100 0000006f 00 0 00000000 0

// ==== vlog.f ====
core_pkg.sv
fetch_stage.sv
decode_issue_stage.sv
ex_stage.sv
commit_stage.sv
mini_core.sv
tb_mini_core.sv

// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - core_pkg.sv
  - fetch_stage.sv
  - decode_issue_stage.sv
  - ex_stage.sv
  - commit_stage.sv
  - mini_core.sv
  - target: simulation
    files:
      - tb_mini_core.sv
